// ==== filelist.f ====
+incdir+.
rvc_pkg.sv
rvc_expander.sv
fetch_aligner.sv
inst_out_stage.sv
rvc_cfg_regs.sv
rvc_fetch_top.sv
tb_rvc_fetch.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f filelist.f --top-module rvc_fetch_top

sim:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_rvc_fetch -o simv
	./obj_dir/simv | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_rvc_ref.svh ====
`ifndef TB_RVC_REF_SVH
`define TB_RVC_REF_SVH

// Expected 32-bit form of a compressed instruction or zero when illegal
function automatic inst32_t expand_rvc(input inst16_t c, input logic c_en, output logic ill);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs2p;
    logic [11:0] ci;
    logic [11:0] lw_o;
    logic [11:0] ld_o;
    logic [11:0] sw_o;
    logic [11:0] sd_o;
    logic [20:0] jo;
    logic [12:0] bo;
    logic [2:0]  aluf;
    inst32_t     r;
    rd   = c[11:7];
    rs2  = c[6:2];
    rdp  = {2'b01, c[9:7]};
    rs2p = {2'b01, c[4:2]};
    ci   = {{7{c[12]}}, c[6:2]};
    lw_o = {5'd0, c[5], c[12:10], c[6], 2'd0};
    ld_o = {4'd0, c[6:5], c[12:10], 3'd0};
    sw_o = {4'd0, c[8:7], c[12:9], 2'd0};
    sd_o = {3'd0, c[9:7], c[12:10], 3'd0};
    jo   = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    bo   = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    r    = '0;
    case ({c[1:0], c[15:13]})
        5'b00_000: if (c[12:5] != 0) r = {2'b0, c[10:7], c[12:11], c[5], c[6], 2'b0,
                                           5'd2, 3'b000, rs2p, OPC_OP_IMM};
        5'b00_001: r = {ld_o, rdp, 3'b011, rs2p, OPC_LOAD_FP};
        5'b00_010: r = {lw_o, rdp, 3'b010, rs2p, OPC_LOAD};
        5'b00_011: r = {lw_o, rdp, 3'b010, rs2p, OPC_LOAD_FP};
        5'b00_101: r = {ld_o[11:5], rs2p, rdp, 3'b011, ld_o[4:0], OPC_STORE_FP};
        5'b00_110: r = {lw_o[11:5], rs2p, rdp, 3'b010, lw_o[4:0], OPC_STORE};
        5'b00_111: r = {lw_o[11:5], rs2p, rdp, 3'b010, lw_o[4:0], OPC_STORE_FP};
        5'b01_000: if (rd != 0 || c[12:2] == 0) r = {ci, rd, 3'b000, rd, OPC_OP_IMM};
        5'b01_001: r = {jo[20], jo[10:1], jo[11], jo[19:12], 5'd1, OPC_JAL};
        5'b01_010: r = {ci, 5'd0, 3'b000, rd, OPC_OP_IMM};
        5'b01_011: begin
            if (rd == 2) begin
                r = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'd0, 5'd2, 3'b000, 5'd2, OPC_OP_IMM};
            end else if (rd != 0) begin
                r = {{15{c[12]}}, c[6:2], rd, OPC_LUI};
            end
        end
        5'b01_100: begin
            case (c[11:10])
                2'd0: if (!c[12]) r = {7'd0, rs2, rdp, 3'b101, rdp, OPC_OP_IMM};
                2'd1: if (!c[12]) r = {7'h20, rs2, rdp, 3'b101, rdp, OPC_OP_IMM};
                2'd2: r = {ci, rdp, 3'b111, rdp, OPC_OP_IMM};
                default: begin
                    case (c[6:5])
                        2'd0: aluf = 3'b000;
                        2'd1: aluf = 3'b100;
                        2'd2: aluf = 3'b110;
                        default: aluf = 3'b111;
                    endcase
                    if (!c[12]) r = {(c[6:5] == 0) ? 7'h20 : 7'h00, rs2p, rdp, aluf, rdp, OPC_OP};
                end
            endcase
        end
        5'b01_101: r = {jo[20], jo[10:1], jo[11], jo[19:12], 5'd0, OPC_JAL};
        5'b01_110: r = {bo[12], bo[10:5], 5'd0, rdp, 3'b000, bo[4:1], bo[11], OPC_BRANCH};
        5'b01_111: r = {bo[12], bo[10:5], 5'd0, rdp, 3'b001, bo[4:1], bo[11], OPC_BRANCH};
        5'b10_000: if (!c[12]) r = {7'd0, rs2, rd, 3'b001, rd, OPC_OP_IMM};
        5'b10_001: r = {3'd0, c[4:2], c[12], c[6:5], 3'd0, 5'd2, 3'b011, rd, OPC_LOAD_FP};
        5'b10_010: r = {4'd0, c[3:2], c[12], c[6:4], 2'd0, 5'd2, 3'b010, rd, OPC_LOAD};
        5'b10_011: r = {4'd0, c[3:2], c[12], c[6:4], 2'd0, 5'd2, 3'b010, rd, OPC_LOAD_FP};
        5'b10_100: begin
            if (!c[12]) begin
                if (rs2 == 0) begin
                    r = {12'd0, rd, 3'd0, 5'd0, OPC_JALR};
                end else begin
                    r = {7'd0, rs2, 5'd0, 3'd0, rd, OPC_OP};
                end
            end else if (rd == 0 && rs2 == 0) begin
                r = {12'd1, 13'd0, OPC_SYSTEM};
            end else if (rs2 == 0) begin
                r = {12'd0, rd, 3'd0, 5'd1, OPC_JALR};
            end else if (rd != 0) begin
                r = {7'd0, rs2, rd, 3'd0, rd, OPC_OP};
            end
        end
        5'b10_101: r = {sd_o[11:5], rs2, 5'd2, 3'b011, sd_o[4:0], OPC_STORE_FP};
        5'b10_110: r = {sw_o[11:5], rs2, 5'd2, 3'b010, sw_o[4:0], OPC_STORE};
        5'b10_111: r = {sw_o[11:5], rs2, 5'd2, 3'b010, sw_o[4:0], OPC_STORE_FP};
        default: r = '0;
    endcase
    // Every legal expansion has a nonzero opcode
    ill = (r == '0) || !c_en;
    return ill ? '0 : r;
endfunction

task automatic report_mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
    fail_count++;
    $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    $display("sim failed");
    $fatal(1);
endtask

task automatic check_inst(input string what, input inst32_t got, input inst32_t exp);
    if (got !== exp) report_mismatch(what, got, exp);
endtask

task automatic check_pc(input string what, input addr_t got, input addr_t exp);
    if (got !== exp) report_mismatch(what, got, exp);
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
endtask

task automatic check_cfg(input string what, input cfg_data_t got, input cfg_data_t exp);
    if (got !== exp) report_mismatch(what, got, exp);
endtask

`endif

// ==== tb_rvc_fetch.sv ====
`timescale 1ns/1ns
module tb_rvc_fetch import rvc_pkg::*; ();
    localparam addr_t START_PC = 32'h0000_1000;
    localparam int    DLY      = 10;
    localparam int    TIMEOUT  = 5000;

    logic      clk_i, rst_n_i, fetch_req_i, fetch_ack_o, inst_ack_i, cfg_we_i;
    inst32_t   fetch_data_i, inst_o;
    logic      inst_req_o, inst_is16_o, inst_illegal_o;
    addr_t     inst_pc_o;
    cfg_addr_t cfg_addr_i;
    cfg_data_t cfg_wdata_i, cfg_rdata_o;

    integer    seed;
    integer    ack_seed;
    int        fail_count, n_expected, n_checked, cnt_c, cnt_ill;
    inst16_t   hw_q[$];
    inst32_t   exp_inst_q[$], rx_inst[$];
    logic      exp_is16_q[$], exp_ill_q[$], rx_is16[$], rx_ill[$];
    addr_t     rx_pc[$];

    `include "tb_rvc_ref.svh"

    rvc_fetch_top #(.RESET_PC(START_PC), .CNT_W(16)) dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic abort_on_timeout(input string msg);
        $display("Timeout: %s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic add16(input inst16_t h, input logic en);
        logic ill;
        inst32_t e;
        e = expand_rvc(h, en, ill);
        hw_q.push_back(h);
        exp_inst_q.push_back(e);
        exp_is16_q.push_back(1'b1);
        exp_ill_q.push_back(ill);
        n_expected++;
    endtask

    task automatic add32(input inst32_t w);
        w[1:0] = 2'b11;
        hw_q.push_back(w[15:0]);
        hw_q.push_back(w[31:16]);
        exp_inst_q.push_back(w);
        exp_is16_q.push_back(1'b0);
        exp_ill_q.push_back(1'b0);
        n_expected++;
    endtask

    task automatic add_random(input int n, input logic en);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            if (r[31]) begin
                add32($random(seed));
            end else begin
                if (r[1:0] == 2'b11) r[1:0] = 2'b10;
                add16(r[15:0], en);
            end
        end
        // A lone trailing halfword would never form a word
        if (hw_q.size() % 2 != 0) add16(16'h0001, en);
    endtask

    task automatic send_word(input inst32_t w);
        int t;
        repeat ($unsigned($random(seed)) % 3) @(posedge clk_i);
        @(posedge clk_i);
        #DLY;
        fetch_req_i  = 1'b1;
        fetch_data_i = w;
        t = 0;
        while (fetch_ack_o !== 1'b1) begin
            @(posedge clk_i);
            #DLY;
            t++;
            if (t > TIMEOUT) abort_on_timeout("fetch_ack_o never rose");
        end
        fetch_req_i = 1'b0;
        t = 0;
        while (fetch_ack_o !== 1'b0) begin
            @(posedge clk_i);
            #DLY;
            t++;
            if (t > TIMEOUT) abort_on_timeout("fetch_ack_o never fell");
        end
    endtask

    task automatic run_program();
        int t;
        inst16_t lo;
        while (hw_q.size() >= 2) begin
            lo = hw_q.pop_front();
            send_word({hw_q.pop_front(), lo});
        end
        t = 0;
        while (n_checked != n_expected) begin
            @(posedge clk_i);
            t++;
            if (t > TIMEOUT) abort_on_timeout("instructions missing at decode");
        end
    endtask

    task automatic cfg_write(input cfg_addr_t a, input cfg_data_t d);
        @(posedge clk_i);
        #DLY;
        cfg_we_i    = 1'b1;
        cfg_addr_i  = a;
        cfg_wdata_i = d;
        @(posedge clk_i);
        #DLY;
        cfg_we_i = 1'b0;
    endtask

    task automatic cfg_expect(input string what, input cfg_addr_t a, input cfg_data_t d);
        @(posedge clk_i);
        #DLY;
        cfg_addr_i = a;
        @(posedge clk_i);
        #DLY;
        check_cfg(what, cfg_rdata_o, d);
    endtask

    // Decode side with a random ack delay
    initial begin : responder
        int t;
        inst32_t i_v;
        addr_t p_v;
        logic s_v, l_v;
        forever begin
            t = 0;
            while (inst_req_o !== 1'b1) begin
                @(posedge clk_i);
                #DLY;
                t++;
                if (t > TIMEOUT) abort_on_timeout("inst_req_o never rose");
            end
            i_v = inst_o;
            p_v = inst_pc_o;
            s_v = inst_is16_o;
            l_v = inst_illegal_o;
            repeat ($unsigned($random(ack_seed)) % 5) @(posedge clk_i);
            #DLY;
            inst_ack_i = 1'b1;
            t = 0;
            while (inst_req_o !== 1'b0) begin
                @(posedge clk_i);
                #DLY;
                t++;
                if (t > TIMEOUT) abort_on_timeout("inst_req_o never fell");
            end
            inst_ack_i = 1'b0;
            rx_inst.push_back(i_v);
            rx_pc.push_back(p_v);
            rx_is16.push_back(s_v);
            rx_ill.push_back(l_v);
        end
    end

    initial begin : compare_results
        int t;
        addr_t pc_exp;
        logic is16;
        pc_exp = START_PC;
        forever begin
            t = 0;
            while (rx_inst.size() == 0) begin
                @(posedge clk_i);
                t++;
                if (t > TIMEOUT) abort_on_timeout("checker starved");
            end
            is16 = exp_is16_q.pop_front();
            check_inst("inst_o", rx_inst.pop_front(), exp_inst_q.pop_front());
            check_pc("inst_pc_o", rx_pc.pop_front(), pc_exp);
            check_flag("inst_is16_o", rx_is16.pop_front(), is16);
            check_flag("inst_illegal_o", rx_ill.pop_front(), exp_ill_q[0]);
            cnt_c   += int'(is16);
            cnt_ill += int'(exp_ill_q.pop_front());
            pc_exp  += is16 ? 2 : 4;
            n_checked++;
        end
    end

    initial begin : main
        inst16_t dir16[$];
        dir16 = '{16'h1fe0, 16'h2004, 16'h4398, 16'h6398, 16'ha004, 16'hc3d8,
                  16'he3d8, 16'h0001, 16'h0505, 16'h3ffd, 16'h557d, 16'h7101,
                  16'h6785, 16'h8095, 16'h8495, 16'h9895, 16'h8c89, 16'h8ca9,
                  16'h8cc9, 16'h8ce9, 16'ha8a1, 16'hc8f5, 16'he8f5, 16'h0506,
                  16'h2502, 16'h4512, 16'h6512, 16'h8082, 16'h852a, 16'h9002,
                  16'h9582, 16'h952a, 16'ha02a, 16'hc62a, 16'he62a,
                  16'h0000, 16'h8000, 16'h9c89, 16'h6001, 16'h1006};
        seed = 32'h6fba30d4;
        ack_seed = seed;
        rst_n_i = 1'b0;
        fetch_req_i = 1'b0;
        fetch_data_i = '0;
        inst_ack_i = 1'b0;
        cfg_we_i = 1'b0;
        cfg_addr_i = CFG_CTRL;
        cfg_wdata_i = '0;
        repeat (3) @(posedge clk_i);
        #DLY;
        rst_n_i = 1'b1;
        // Directed forms with 32-bit words dropped in to force straddling
        foreach (dir16[i]) begin
            add16(dir16[i], 1'b1);
            if (i % 3 == 0) add32($random(seed));
        end
        add_random(80, 1'b1);
        run_program();
        cfg_write(CFG_CTRL, 32'd0);
        cfg_expect("CFG_CTRL", CFG_CTRL, 32'd0);
        add_random(40, 1'b0);
        run_program();
        cfg_write(CFG_CTRL, 32'd1);
        add_random(80, 1'b1);
        run_program();
        cfg_expect("CFG_CNT_C", CFG_CNT_C, cfg_data_t'(cnt_c));
        cfg_expect("CFG_CNT_ILL", CFG_CNT_ILL, cfg_data_t'(cnt_ill));
        cfg_write(CFG_CNT_C, 32'd0);
        cfg_write(CFG_CNT_ILL, 32'd0);
        cfg_expect("CFG_CNT_C cleared", CFG_CNT_C, 32'd0);
        cfg_expect("CFG_CNT_ILL cleared", CFG_CNT_ILL, 32'd0);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== rvc_fetch_top.sv ====
`timescale 1ns/1ns
module rvc_fetch_top import rvc_pkg::*; #(
    parameter addr_t RESET_PC = 32'h0000_0000,
    parameter int    CNT_W    = 16
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      fetch_req_i,
    input  inst32_t   fetch_data_i,
    output logic      fetch_ack_o,
    output logic      inst_req_o,
    output inst32_t   inst_o,
    output addr_t     inst_pc_o,
    output logic      inst_is16_o,
    output logic      inst_illegal_o,
    input  logic      inst_ack_i,
    input  logic      cfg_we_i,
    input  cfg_addr_t cfg_addr_i,
    input  cfg_data_t cfg_wdata_i,
    output cfg_data_t cfg_rdata_o
);
    logic    al_valid;
    inst32_t al_raw;
    logic    al_is16;
    addr_t   al_pc;
    logic    out_ready;
    inst32_t exp_inst;
    logic    exp_illegal;
    logic    c_en;
    logic    ev_c;
    logic    ev_ill;

    fetch_aligner #(
        .RESET_PC (RESET_PC)
    ) u_aligner (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_req_i  (fetch_req_i),
        .fetch_data_i (fetch_data_i),
        .fetch_ack_o  (fetch_ack_o),
        .al_valid_o   (al_valid),
        .al_raw_o     (al_raw),
        .al_is16_o    (al_is16),
        .al_pc_o      (al_pc),
        .out_ready_i  (out_ready)
    );

    rvc_expander u_expander (
        .inst16_i  (al_raw[15:0]),
        .c_en_i    (c_en),
        .inst32_o  (exp_inst),
        .illegal_o (exp_illegal)
    );

    inst_out_stage u_out_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .al_valid_i     (al_valid),
        .al_raw_i       (al_raw),
        .al_is16_i      (al_is16),
        .al_pc_i        (al_pc),
        .exp_inst_i     (exp_inst),
        .exp_illegal_i  (exp_illegal),
        .out_ready_o    (out_ready),
        .inst_req_o     (inst_req_o),
        .inst_o         (inst_o),
        .inst_pc_o      (inst_pc_o),
        .inst_is16_o    (inst_is16_o),
        .inst_illegal_o (inst_illegal_o),
        .inst_ack_i     (inst_ack_i),
        .ev_c_o         (ev_c),
        .ev_ill_o       (ev_ill)
    );

    rvc_cfg_regs #(
        .CNT_W (CNT_W)
    ) u_cfg (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .c_en_o      (c_en),
        .ev_c_i      (ev_c),
        .ev_ill_i    (ev_ill)
    );

endmodule

// ==== rvc_cfg_regs.sv ====
`timescale 1ns/1ns
module rvc_cfg_regs import rvc_pkg::*; #(
    parameter int CNT_W = 16
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      cfg_we_i,
    input  cfg_addr_t cfg_addr_i,
    input  cfg_data_t cfg_wdata_i,
    output cfg_data_t cfg_rdata_o,
    output logic      c_en_o,
    input  logic      ev_c_i,
    input  logic      ev_ill_i
);
    logic             c_en_q;
    logic [CNT_W-1:0] cnt_c_q;
    logic [CNT_W-1:0] cnt_ill_q;

    assign c_en_o = c_en_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            c_en_q    <= 1'b1;
            cnt_c_q   <= '0;
            cnt_ill_q <= '0;
        end else begin
            if (cfg_we_i && cfg_addr_i == CFG_CTRL) begin
                c_en_q <= cfg_wdata_i[0];
            end
            // Clear wins over a same-cycle event, counters stick at all ones
            if (cfg_we_i && cfg_addr_i == CFG_CNT_C) begin
                cnt_c_q <= '0;
            end else if (ev_c_i && cnt_c_q != '1) begin
                cnt_c_q <= cnt_c_q + 1'b1;
            end
            if (cfg_we_i && cfg_addr_i == CFG_CNT_ILL) begin
                cnt_ill_q <= '0;
            end else if (ev_ill_i && cnt_ill_q != '1) begin
                cnt_ill_q <= cnt_ill_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (cfg_addr_i)
            CFG_CTRL:    cfg_rdata_o = cfg_data_t'(c_en_q);
            CFG_CNT_C:   cfg_rdata_o = cfg_data_t'(cnt_c_q);
            CFG_CNT_ILL: cfg_rdata_o = cfg_data_t'(cnt_ill_q);
            default:     cfg_rdata_o = '0;
        endcase
    end

endmodule

// ==== inst_out_stage.sv ====
`timescale 1ns/1ns
module inst_out_stage import rvc_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    al_valid_i,
    input  inst32_t al_raw_i,
    input  logic    al_is16_i,
    input  addr_t   al_pc_i,
    input  inst32_t exp_inst_i,
    input  logic    exp_illegal_i,
    output logic    out_ready_o,
    output logic    inst_req_o,
    output inst32_t inst_o,
    output addr_t   inst_pc_o,
    output logic    inst_is16_o,
    output logic    inst_illegal_o,
    input  logic    inst_ack_i,
    output logic    ev_c_o,
    output logic    ev_ill_o
);
    typedef enum logic [1:0] {OS_IDLE, OS_REQ, OS_DROP} os_state_t;

    os_state_t os_state;
    logic      accept;

    assign out_ready_o = os_state == OS_IDLE;
    assign inst_req_o  = os_state == OS_REQ;
    assign accept      = inst_req_o && inst_ack_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            os_state <= OS_IDLE;
            ev_c_o   <= 1'b0;
            ev_ill_o <= 1'b0;
        end else begin
            ev_c_o   <= accept && inst_is16_o;
            ev_ill_o <= accept && inst_illegal_o;
            case (os_state)
                OS_IDLE: if (al_valid_i) os_state <= OS_REQ;
                OS_REQ:  if (inst_ack_i) os_state <= OS_DROP;
                OS_DROP: if (!inst_ack_i) os_state <= OS_IDLE;
                default: os_state <= OS_IDLE;
            endcase
        end
    end

    // Held stable for the whole request phase
    always_ff @(posedge clk_i) begin
        if (al_valid_i && out_ready_o) begin
            inst_o         <= al_is16_i ? exp_inst_i : al_raw_i;
            inst_pc_o      <= al_pc_i;
            inst_is16_o    <= al_is16_i;
            inst_illegal_o <= al_is16_i && exp_illegal_i;
        end
    end

endmodule

// ==== fetch_aligner.sv ====
`timescale 1ns/1ns
module fetch_aligner import rvc_pkg::*; #(
    parameter addr_t RESET_PC = 32'h0000_0000
) (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    fetch_req_i,
    input  inst32_t fetch_data_i,
    output logic    fetch_ack_o,
    output logic    al_valid_o,
    output inst32_t al_raw_o,
    output logic    al_is16_o,
    output addr_t   al_pc_o,
    input  logic    out_ready_i
);
    typedef enum logic {FA_IDLE, FA_ACK} fa_state_t;

    fa_state_t   fa_state;
    logic [47:0] hw_buf;
    logic [1:0]  hw_cnt;
    logic [1:0]  hw_left;
    logic [47:0] buf_shifted;
    logic [47:0] buf_next;
    logic        head_is16;
    logic        pop;
    logic        take;
    addr_t       pc_q;

    // Oldest halfword sits in bits 15:0
    assign head_is16  = hw_buf[1:0] != 2'b11;
    assign al_valid_o = head_is16 ? (hw_cnt >= 2'd1) : (hw_cnt >= 2'd2);
    assign al_raw_o   = hw_buf[31:0];
    assign al_is16_o  = head_is16;
    assign al_pc_o    = pc_q;
    assign pop        = al_valid_o && out_ready_i;

    // A word fits only while at most one halfword is buffered
    assign take        = (fa_state == FA_IDLE) && fetch_req_i && (hw_cnt <= 2'd1);
    assign fetch_ack_o = fa_state == FA_ACK;

    always_comb begin
        hw_left     = hw_cnt;
        buf_shifted = hw_buf;
        if (pop) begin
            if (head_is16) begin
                hw_left     = hw_cnt - 2'd1;
                buf_shifted = {16'h0000, hw_buf[47:16]};
            end else begin
                hw_left     = hw_cnt - 2'd2;
                buf_shifted = {32'h0000_0000, hw_buf[47:32]};
            end
        end
    end

    // New word lands right above what is left after the pop
    always_comb begin
        buf_next = buf_shifted;
        if (take) begin
            if (hw_left == 2'd0) begin
                buf_next[31:0] = fetch_data_i;
            end else begin
                buf_next[47:16] = fetch_data_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fa_state <= FA_IDLE;
            hw_cnt   <= 2'd0;
            pc_q     <= RESET_PC;
        end else begin
            hw_cnt <= take ? hw_left + 2'd2 : hw_left;
            if (pop) begin
                pc_q <= pc_q + (head_is16 ? addr_t'(2) : addr_t'(4));
            end
            case (fa_state)
                FA_IDLE: if (take) fa_state <= FA_ACK;
                FA_ACK:  if (!fetch_req_i) fa_state <= FA_IDLE;
                default: fa_state <= FA_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        hw_buf <= buf_next;
    end

endmodule

// ==== rvc_expander.sv ====
`timescale 1ns/1ns
module rvc_expander import rvc_pkg::*; (
    input  inst16_t inst16_i,
    input  logic    c_en_i,
    output inst32_t inst32_o,
    output logic    illegal_o
);
    logic        q0, q1, q2;
    logic [2:0]  f3;
    logic [4:0]  rd, rs2, rd_p, rs2_p;
    logic        rd_nz, rs2_nz;
    logic        alu, cr, rr;
    logic        c_addi4spn, c_fld, c_lw, c_flw, c_fsd, c_sw, c_fsw;
    logic        c_addi, c_jal, c_li, c_addi16sp, c_lui;
    logic        c_srli, c_srai, c_andi, c_sub, c_xor, c_or, c_and;
    logic        c_j, c_beqz, c_bnez;
    logic        c_slli, c_fldsp, c_lwsp, c_flwsp;
    logic        c_jr, c_mv, c_ebreak, c_jalr, c_add;
    logic        c_fsdsp, c_swsp, c_fswsp;
    logic        any_form;
    logic [11:0] imm_ci, imm_4spn, imm_16sp, imm_w, imm_d;
    logic [11:0] imm_lwsp, imm_ldsp, imm_swsp, imm_sdsp;
    logic [20:0] off_j;
    logic [12:0] off_b;
    inst32_t     exp;

    function automatic inst32_t enc_r(logic [6:0] f7, logic [4:0] rs2_f, logic [4:0] rs1_f,
                                      logic [2:0] f3_f, logic [4:0] rd_f, logic [6:0] opc);
        return {f7, rs2_f, rs1_f, f3_f, rd_f, opc};
    endfunction

    function automatic inst32_t enc_i(logic [11:0] imm, logic [4:0] rs1_f, logic [2:0] f3_f,
                                      logic [4:0] rd_f, logic [6:0] opc);
        return {imm, rs1_f, f3_f, rd_f, opc};
    endfunction

    function automatic inst32_t enc_s(logic [11:0] imm, logic [4:0] rs2_f, logic [4:0] rs1_f,
                                      logic [2:0] f3_f, logic [6:0] opc);
        return {imm[11:5], rs2_f, rs1_f, f3_f, imm[4:0], opc};
    endfunction

    function automatic inst32_t enc_b(logic [12:0] off, logic [4:0] rs1_f, logic [2:0] f3_f);
        return {off[12], off[10:5], 5'd0, rs1_f, f3_f, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic inst32_t enc_j(logic [20:0] off, logic [4:0] rd_f);
        return {off[20], off[10:1], off[11], off[19:12], rd_f, OPC_JAL};
    endfunction

    assign q0 = inst16_i[1:0] == 2'b00;
    assign q1 = inst16_i[1:0] == 2'b01;
    assign q2 = inst16_i[1:0] == 2'b10;
    assign f3 = inst16_i[15:13];

    assign rd     = inst16_i[11:7];
    assign rs2    = inst16_i[6:2];
    // Short register fields select x8..x15
    assign rd_p   = {2'b01, inst16_i[9:7]};
    assign rs2_p  = {2'b01, inst16_i[4:2]};
    assign rd_nz  = rd != 5'd0;
    assign rs2_nz = rs2 != 5'd0;

    // Quadrant 0
    assign c_addi4spn = q0 & (f3 == 3'd0) & (inst16_i[12:5] != 8'd0);
    assign c_fld      = q0 & (f3 == 3'd1);
    assign c_lw       = q0 & (f3 == 3'd2);
    assign c_flw      = q0 & (f3 == 3'd3);
    assign c_fsd      = q0 & (f3 == 3'd5);
    assign c_sw       = q0 & (f3 == 3'd6);
    assign c_fsw      = q0 & (f3 == 3'd7);

    // Quadrant 1, C.NOP folds into C.ADDI
    assign c_addi     = q1 & (f3 == 3'd0) & (rd_nz | (inst16_i[12:2] == 11'd0));
    assign c_jal      = q1 & (f3 == 3'd1);
    assign c_li       = q1 & (f3 == 3'd2);
    assign c_addi16sp = q1 & (f3 == 3'd3) & (rd == 5'd2);
    assign c_lui      = q1 & (f3 == 3'd3) & rd_nz & (rd != 5'd2);
    assign alu        = q1 & (f3 == 3'd4);
    assign c_srli     = alu & (inst16_i[11:10] == 2'd0) & ~inst16_i[12];
    assign c_srai     = alu & (inst16_i[11:10] == 2'd1) & ~inst16_i[12];
    assign c_andi     = alu & (inst16_i[11:10] == 2'd2);
    assign rr         = alu & (inst16_i[11:10] == 2'd3) & ~inst16_i[12];
    assign c_sub      = rr & (inst16_i[6:5] == 2'd0);
    assign c_xor      = rr & (inst16_i[6:5] == 2'd1);
    assign c_or       = rr & (inst16_i[6:5] == 2'd2);
    assign c_and      = rr & (inst16_i[6:5] == 2'd3);
    assign c_j        = q1 & (f3 == 3'd5);
    assign c_beqz     = q1 & (f3 == 3'd6);
    assign c_bnez     = q1 & (f3 == 3'd7);

    // Quadrant 2
    assign c_slli     = q2 & (f3 == 3'd0) & ~inst16_i[12];
    assign c_fldsp    = q2 & (f3 == 3'd1);
    assign c_lwsp     = q2 & (f3 == 3'd2);
    assign c_flwsp    = q2 & (f3 == 3'd3);
    assign cr         = q2 & (f3 == 3'd4);
    assign c_jr       = cr & ~inst16_i[12] & ~rs2_nz;
    assign c_mv       = cr & ~inst16_i[12] & rs2_nz;
    assign c_ebreak   = cr & inst16_i[12] & ~rd_nz & ~rs2_nz;
    assign c_jalr     = cr & inst16_i[12] & rd_nz & ~rs2_nz;
    assign c_add      = cr & inst16_i[12] & rd_nz & rs2_nz;
    assign c_fsdsp    = q2 & (f3 == 3'd5);
    assign c_swsp     = q2 & (f3 == 3'd6);
    assign c_fswsp    = q2 & (f3 == 3'd7);

    assign any_form = c_addi4spn | c_fld | c_lw | c_flw | c_fsd | c_sw | c_fsw |
                      c_addi | c_jal | c_li | c_addi16sp | c_lui |
                      c_srli | c_srai | c_andi | c_sub | c_xor | c_or | c_and |
                      c_j | c_beqz | c_bnez |
                      c_slli | c_fldsp | c_lwsp | c_flwsp |
                      c_jr | c_mv | c_ebreak | c_jalr | c_add |
                      c_fsdsp | c_swsp | c_fswsp;

    // Unscrambled immediates
    assign imm_ci   = {{6{inst16_i[12]}}, inst16_i[12], inst16_i[6:2]};
    assign imm_4spn = {2'b00, inst16_i[10:7], inst16_i[12:11], inst16_i[5], inst16_i[6], 2'b00};
    assign imm_16sp = {{3{inst16_i[12]}}, inst16_i[4:3], inst16_i[5], inst16_i[2], inst16_i[6],
                       4'b0000};
    assign imm_w    = {5'd0, inst16_i[5], inst16_i[12:10], inst16_i[6], 2'b00};
    assign imm_d    = {4'd0, inst16_i[6:5], inst16_i[12:10], 3'b000};
    assign imm_lwsp = {4'd0, inst16_i[3:2], inst16_i[12], inst16_i[6:4], 2'b00};
    assign imm_ldsp = {3'd0, inst16_i[4:2], inst16_i[12], inst16_i[6:5], 3'b000};
    assign imm_swsp = {4'd0, inst16_i[8:7], inst16_i[12:9], 2'b00};
    assign imm_sdsp = {3'd0, inst16_i[9:7], inst16_i[12:10], 3'b000};
    assign off_j    = {{10{inst16_i[12]}}, inst16_i[8], inst16_i[10:9], inst16_i[6], inst16_i[7],
                       inst16_i[2], inst16_i[11], inst16_i[5:3], 1'b0};
    assign off_b    = {{5{inst16_i[12]}}, inst16_i[6:5], inst16_i[2], inst16_i[11:10],
                       inst16_i[4:3], 1'b0};

    always_comb begin
        exp = '0;
        if (c_addi4spn)      exp = enc_i(imm_4spn, 5'd2, 3'b000, rs2_p, OPC_OP_IMM);
        else if (c_fld)      exp = enc_i(imm_d, rd_p, 3'b011, rs2_p, OPC_LOAD_FP);
        else if (c_lw)       exp = enc_i(imm_w, rd_p, 3'b010, rs2_p, OPC_LOAD);
        else if (c_flw)      exp = enc_i(imm_w, rd_p, 3'b010, rs2_p, OPC_LOAD_FP);
        else if (c_fsd)      exp = enc_s(imm_d, rs2_p, rd_p, 3'b011, OPC_STORE_FP);
        else if (c_sw)       exp = enc_s(imm_w, rs2_p, rd_p, 3'b010, OPC_STORE);
        else if (c_fsw)      exp = enc_s(imm_w, rs2_p, rd_p, 3'b010, OPC_STORE_FP);
        else if (c_addi)     exp = enc_i(imm_ci, rd, 3'b000, rd, OPC_OP_IMM);
        else if (c_jal)      exp = enc_j(off_j, 5'd1);
        else if (c_li)       exp = enc_i(imm_ci, 5'd0, 3'b000, rd, OPC_OP_IMM);
        else if (c_addi16sp) exp = enc_i(imm_16sp, 5'd2, 3'b000, 5'd2, OPC_OP_IMM);
        else if (c_lui)      exp = {{14{inst16_i[12]}}, inst16_i[12], inst16_i[6:2], rd, OPC_LUI};
        else if (c_srli)     exp = enc_i({7'b0000000, rs2}, rd_p, 3'b101, rd_p, OPC_OP_IMM);
        else if (c_srai)     exp = enc_i({7'b0100000, rs2}, rd_p, 3'b101, rd_p, OPC_OP_IMM);
        else if (c_andi)     exp = enc_i(imm_ci, rd_p, 3'b111, rd_p, OPC_OP_IMM);
        else if (c_sub)      exp = enc_r(7'b0100000, rs2_p, rd_p, 3'b000, rd_p, OPC_OP);
        else if (c_xor)      exp = enc_r(7'b0000000, rs2_p, rd_p, 3'b100, rd_p, OPC_OP);
        else if (c_or)       exp = enc_r(7'b0000000, rs2_p, rd_p, 3'b110, rd_p, OPC_OP);
        else if (c_and)      exp = enc_r(7'b0000000, rs2_p, rd_p, 3'b111, rd_p, OPC_OP);
        else if (c_j)        exp = enc_j(off_j, 5'd0);
        else if (c_beqz)     exp = enc_b(off_b, rd_p, 3'b000);
        else if (c_bnez)     exp = enc_b(off_b, rd_p, 3'b001);
        else if (c_slli)     exp = enc_i({7'b0000000, rs2}, rd, 3'b001, rd, OPC_OP_IMM);
        else if (c_fldsp)    exp = enc_i(imm_ldsp, 5'd2, 3'b011, rd, OPC_LOAD_FP);
        else if (c_lwsp)     exp = enc_i(imm_lwsp, 5'd2, 3'b010, rd, OPC_LOAD);
        else if (c_flwsp)    exp = enc_i(imm_lwsp, 5'd2, 3'b010, rd, OPC_LOAD_FP);
        else if (c_jr)       exp = enc_i(12'd0, rd, 3'b000, 5'd0, OPC_JALR);
        else if (c_mv)       exp = enc_r(7'b0000000, rs2, 5'd0, 3'b000, rd, OPC_OP);
        else if (c_ebreak)   exp = enc_i(12'd1, 5'd0, 3'b000, 5'd0, OPC_SYSTEM);
        else if (c_jalr)     exp = enc_i(12'd0, rd, 3'b000, 5'd1, OPC_JALR);
        else if (c_add)      exp = enc_r(7'b0000000, rs2, rd, 3'b000, rd, OPC_OP);
        else if (c_fsdsp)    exp = enc_s(imm_sdsp, rs2, 5'd2, 3'b011, OPC_STORE_FP);
        else if (c_swsp)     exp = enc_s(imm_swsp, rs2, 5'd2, 3'b010, OPC_STORE);
        else if (c_fswsp)    exp = enc_s(imm_swsp, rs2, 5'd2, 3'b010, OPC_STORE_FP);
    end

    // Reserved encodings and a disabled C extension both trap
    assign illegal_o = ~(any_form & c_en_i);
    assign inst32_o  = illegal_o ? '0 : exp;

endmodule

// ==== rvc_pkg.sv ====
package rvc_pkg;

    typedef logic [15:0] inst16_t;
    typedef logic [31:0] inst32_t;
    typedef logic [31:0] addr_t;
    typedef logic [1:0]  cfg_addr_t;
    typedef logic [31:0] cfg_data_t;

    // Configuration register map
    localparam cfg_addr_t CFG_CTRL    = 2'd0;
    localparam cfg_addr_t CFG_CNT_C   = 2'd1;
    localparam cfg_addr_t CFG_CNT_ILL = 2'd2;

    // Major opcodes of the 32-bit encodings
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

endpackage
